// ==== common/sdSpiPkg.sv ====
/*
 * Shared types for the SD card SPI master.
 * Holds the APB request and response structs, the card pin struct, the register
 * offsets, the shift engine phases and the Control register bit positions.
 */

`default_nettype none

package sdSpiPkg;

	// driven by the bus master
	typedef struct packed {
		logic [7:0] paddr;
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] pwdata;
	} apbRequest;

	// driven by the slave, pslverr is tied low
	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apbResponse;

	// outputs toward the card
	typedef struct packed {
		logic sclk;
		logic mosi;
		logic csn;
	} spiPins;

	// register byte offsets on the APB side
	typedef enum logic [7:0] {
		Control = 8'h00,
		Data = 8'h04,
		SendLow = 8'h08,
		SendHigh = 8'h0C,
		ReceiveLow = 8'h10,
		ReceiveHigh = 8'h14
	} regOffset;

	// shift engine phases
	// low and high are the two halves of one SCLK period
	typedef enum logic [1:0] {
		Idle,
		Low,
		High
	} engineState;

	// chip select level, written by software
	localparam int CtrlCsn = 0;
	// write starts one byte, read gives busy
	localparam int CtrlStartByte = 1;
	// write starts an eight byte burst
	localparam int CtrlStartBurst = 5;
	// divider sits in bits 31:24
	localparam int CtrlDividerLsb = 24;

endpackage

`default_nettype wire

// ==== sdSpi/spiShiftEngine.sv ====
/*
 * SPI mode 0 shifter for one byte.
 * A startByte pulse runs eight SCLK periods, each half lasting divider + 1
 * clocks. MOSI goes out MSB first, MISO comes back through one sync flop.
 */

`timescale 1ns/1ps
`default_nettype none

module spiShiftEngine (
	input logic clock,
	input logic reset,
	input logic startByte,
	input logic [7:0] txByte,
	input logic [7:0] divider,
	input logic miso,
	output logic sclk,
	output logic mosi,
	output logic [7:0] rxByte,
	output logic busy,
	output logic byteDone
);
	import sdSpiPkg::*;

	engineState state;
	logic [7:0] halfCount;
	logic [2:0] bitCount;
	logic [7:0] txShift;
	logic [7:0] rxShift;
	logic misoSync;
	logic halfDone;
	logic lastBit;
	logic sampleNow;

	// end of the current half period
	assign halfDone = (halfCount == 8'd0);
	assign lastBit = (bitCount == 3'd7);
	// first clock with SCLK high, misoSync already holds the bit
	assign sampleNow = (state == High) && (halfCount == divider);

	assign busy = (state != Idle);
	assign rxByte = rxShift;

	// one flop on the way in from the card
	always_ff @(posedge clock)
	begin
		misoSync <= miso;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= Idle;
			halfCount <= 8'd0;
			bitCount <= 3'd0;
			sclk <= 1'b0;
			mosi <= 1'b1;
			byteDone <= 1'b0;
		end
		else
		begin
			byteDone <= 1'b0;
			case (state)
				Idle:
				begin
					if (startByte)
					begin
						// first bit goes out with the first low phase
						state <= Low;
						halfCount <= divider;
						bitCount <= 3'd0;
						mosi <= txByte[7];
					end
				end
				Low:
				begin
					if (halfDone)
					begin
						state <= High;
						halfCount <= divider;
						sclk <= 1'b1;
					end
					else
					begin
						halfCount <= halfCount - 8'd1;
					end
				end
				High:
				begin
					if (halfDone)
					begin
						sclk <= 1'b0;
						halfCount <= divider;
						if (lastBit)
						begin
							// byte complete, line idles high
							state <= Idle;
							mosi <= 1'b1;
							byteDone <= 1'b1;
						end
						else
						begin
							state <= Low;
							bitCount <= bitCount + 3'd1;
							mosi <= txShift[6];
						end
					end
					else
					begin
						halfCount <= halfCount - 8'd1;
					end
				end
				default:
				begin
					state <= Idle;
				end
			endcase
		end
	end

	// data shifters
	always_ff @(posedge clock)
	begin
		if ((state == Idle) && startByte)
		begin
			txShift <= txByte;
		end
		else if ((state == High) && halfDone && !lastBit)
		begin
			txShift <= {txShift[6:0], 1'b0};
		end
		// msb arrives first
		if (sampleNow)
		begin
			rxShift <= {rxShift[6:0], misoSync};
		end
	end

endmodule

`default_nettype wire

// ==== sdSpi/spiBurstQueue.sv ====
/*
 * Eight byte burst sequencer.
 * Loads the 64-bit send word, feeds the engine one byte at a time lowest first
 * and packs the returned bytes so that the first one ends in bits 7:0.
 */

`timescale 1ns/1ps
`default_nettype none

module spiBurstQueue (
	input logic clock,
	input logic reset,
	input logic startBurst,
	input logic [63:0] sendWord,
	input logic byteDone,
	input logic [7:0] rxByte,
	output logic startByte,
	output logic [7:0] txByte,
	output logic burstBusy,
	output logic [63:0] receiveWord
);

	logic [3:0] remaining;
	logic [63:0] sendQueue;
	logic burstByteDone;
	logic moreBytes;

	assign burstBusy = (remaining != 4'd0);
	// single byte exchanges outside a burst are ignored
	assign burstByteDone = byteDone && burstBusy;
	assign moreBytes = (remaining != 4'd1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			remaining <= 4'd0;
			startByte <= 1'b0;
		end
		else
		begin
			startByte <= 1'b0;
			if (startBurst)
			begin
				remaining <= 4'd8;
				startByte <= 1'b1;
			end
			else if (burstByteDone)
			begin
				// next byte one queue cycle after byteDone
				remaining <= remaining - 4'd1;
				startByte <= moreBytes;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		// send side, emptied bytes refill with 0xFF
		if (startBurst)
		begin
			txByte <= sendWord[7:0];
			sendQueue <= {8'hFF, sendWord[63:8]};
		end
		else if (burstByteDone && moreBytes)
		begin
			txByte <= sendQueue[7:0];
			sendQueue <= {8'hFF, sendQueue[63:8]};
		end
		// receive side enters at the top and moves down
		if (burstByteDone)
		begin
			receiveWord <= {rxByte, receiveWord[63:8]};
		end
	end

endmodule

`default_nettype wire

// ==== sdSpi/sdSpiRegisters.sv ====
/*
 * APB slave for the SD SPI master.
 * Holds Control, the pending Data byte and the send word, and starts byte or
 * burst transfers. Writes that would disturb a running transfer wait on pready.
 */

`timescale 1ns/1ps
`default_nettype none

module sdSpiRegisters #(
	parameter logic [7:0] ResetDivider = 8'd3
) (
	input logic clock,
	input logic reset,
	input sdSpiPkg::apbRequest request,
	output sdSpiPkg::apbResponse response,
	input logic busy,
	input logic burstBusy,
	input logic [7:0] rxByte,
	input logic [63:0] receiveWord,
	output logic startByte,
	output logic startBurst,
	output logic [7:0] txByte,
	output logic [63:0] sendWord,
	output logic [7:0] divider,
	output logic csn
);
	import sdSpiPkg::*;

	regOffset offset;
	logic transferBusy;
	logic access;
	logic hold;
	logic ready;
	logic writeDone;
	logic [31:0] readData;

	assign offset = regOffset'(request.paddr);
	assign transferBusy = busy || burstBusy;
	assign access = request.psel && request.penable;

	// read mux and wait-state rules
	always_comb
	begin
		readData = 32'd0;
		hold = 1'b0;
		case (offset)
			Control:
			begin
				readData[CtrlCsn] = csn;
				readData[CtrlStartByte] = transferBusy;
				readData[CtrlDividerLsb +: 8] = divider;
				// reads never wait, writes wait for the shifter
				hold = request.pwrite && transferBusy;
			end
			Data:
			begin
				readData[7:0] = rxByte;
				hold = transferBusy;
			end
			SendLow:
			begin
				readData = sendWord[31:0];
			end
			SendHigh:
			begin
				readData = sendWord[63:32];
			end
			ReceiveLow:
			begin
				readData = receiveWord[31:0];
			end
			ReceiveHigh:
			begin
				readData = receiveWord[63:32];
			end
			default:
			begin
				readData = 32'd0;
			end
		endcase
	end

	// read data only shows on the completing access cycle
	assign ready = access && !hold;
	assign writeDone = ready && request.pwrite;
	assign response = '{
		prdata: (ready ? readData : 32'd0),
		pready: ready,
		pslverr: 1'b0
	};

	// control state and start pulses
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			csn <= 1'b1;
			divider <= ResetDivider;
			startByte <= 1'b0;
			startBurst <= 1'b0;
		end
		else
		begin
			startByte <= 1'b0;
			startBurst <= 1'b0;
			if (writeDone && (offset == Control))
			begin
				csn <= request.pwdata[CtrlCsn];
				divider <= request.pwdata[CtrlDividerLsb +: 8];
				// byte wins if both start bits are set
				startByte <= request.pwdata[CtrlStartByte];
				startBurst <= request.pwdata[CtrlStartBurst] && !request.pwdata[CtrlStartByte];
			end
		end
	end

	// pending byte and send word
	always_ff @(posedge clock)
	begin
		if (writeDone)
		begin
			case (offset)
				Data:
				begin
					txByte <= request.pwdata[7:0];
				end
				SendLow:
				begin
					sendWord[31:0] <= request.pwdata;
				end
				SendHigh:
				begin
					sendWord[63:32] <= request.pwdata;
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/sdSpiTop.sv ====
/*
 * Top level of the SD card SPI master.
 * Connects the APB register block, the burst queue and the shift engine to the
 * bus and to the card pins. ResetDivider sets the SCLK divider after reset.
 */

`timescale 1ns/1ps
`default_nettype none

module sdSpiTop #(
	parameter logic [7:0] ResetDivider = 8'd3
) (
	input logic clock,
	input logic reset,
	input sdSpiPkg::apbRequest request,
	output sdSpiPkg::apbResponse response,
	input logic miso,
	output sdSpiPkg::spiPins pins
);

	logic regStartByte;
	logic [7:0] regTxByte;
	logic queueStartByte;
	logic [7:0] queueTxByte;
	logic engineStart;
	logic [7:0] engineTxByte;
	logic startBurst;
	logic [63:0] sendWord;
	logic [63:0] receiveWord;
	logic [7:0] divider;
	logic [7:0] rxByte;
	logic busy;
	logic burstBusy;
	logic byteDone;
	logic chipSelect;
	logic engineSclk;
	logic engineMosi;

	// the two start sources never fire together
	assign engineStart = regStartByte || queueStartByte;
	assign engineTxByte = queueStartByte ? queueTxByte : regTxByte;

	assign pins = '{sclk: engineSclk, mosi: engineMosi, csn: chipSelect};

	sdSpiRegisters #(
		.ResetDivider(ResetDivider)
	) registers (
		.clock(clock),
		.reset(reset),
		.request(request),
		.response(response),
		.busy(busy),
		.burstBusy(burstBusy),
		.rxByte(rxByte),
		.receiveWord(receiveWord),
		.startByte(regStartByte),
		.startBurst(startBurst),
		.txByte(regTxByte),
		.sendWord(sendWord),
		.divider(divider),
		.csn(chipSelect)
	);

	spiBurstQueue queue (
		.clock(clock),
		.reset(reset),
		.startBurst(startBurst),
		.sendWord(sendWord),
		.byteDone(byteDone),
		.rxByte(rxByte),
		.startByte(queueStartByte),
		.txByte(queueTxByte),
		.burstBusy(burstBusy),
		.receiveWord(receiveWord)
	);

	spiShiftEngine engine (
		.clock(clock),
		.reset(reset),
		.startByte(engineStart),
		.txByte(engineTxByte),
		.divider(divider),
		.miso(miso),
		.sclk(engineSclk),
		.mosi(engineMosi),
		.rxByte(rxByte),
		.busy(busy),
		.byteDone(byteDone)
	);

endmodule

`default_nettype wire

// ==== dv/sdSpi_assertions.sv ====
/*
 * Concurrent checks on the APB and card pins of sdSpiTop.
 * Bound into every sdSpiTop instance.
 */

`timescale 1ns/1ps
`default_nettype none

module sdSpi_assertions (
	input logic clock,
	input logic reset,
	input sdSpiPkg::apbRequest request,
	input sdSpiPkg::apbResponse response,
	input sdSpiPkg::spiPins pins,
	input logic busy
);

	// failed properties so far
	int failures = 0;
	logic accessWait;

	// any access phase stalled on pready
	assign accessWait = request.psel && request.penable && !response.pready;

	// no clock toward a deselected card or from an idle engine
	sclkQuiet: assert property (@(posedge clock) disable iff (reset)
		(pins.csn || !busy) |-> !pins.sclk)
	else
	begin
		$error("sclk high while csn is high or the engine is idle");
		failures = failures + 1;
	end

	// read data holds while the access waits
	prdataSteady: assert property (@(posedge clock) disable iff (reset)
		accessWait |=> (response.pready || $stable(response.prdata)))
	else
	begin
		$error("prdata moved during a wait state");
		failures = failures + 1;
	end

	// ready only inside an access phase
	readyInAccess: assert property (@(posedge clock) disable iff (reset)
		response.pready |-> (request.psel && request.penable))
	else
	begin
		$error("pready outside an access phase");
		failures = failures + 1;
	end

endmodule

bind sdSpiTop sdSpi_assertions checks (
	.clock(clock),
	.reset(reset),
	.request(request),
	.response(response),
	.pins(pins),
	.busy(busy)
);

`default_nettype wire

// ==== dv/sdSpiTb.sv ====
/*
 * Testbench for the SD card SPI master.
 * Drives APB accesses into sdSpiTop, models the card on the SPI pins and checks
 * single bytes, bursts, SCLK timing, wait states and chip select.
 */

`timescale 1ns/1ps
`default_nettype none

module sdSpiTb;
	import sdSpiPkg::*;

	localparam logic [7:0] ResetDivider = 8'd3;
	localparam int MaxDivider = 7;
	localparam int Iterations = 40;
	// one single byte and one burst per iteration
	localparam int BytesPerIteration = 9;
	// per byte 16 half periods plus room for the APB accesses around it
	localparam int TimeoutCycles =
		Iterations * BytesPerIteration * (16 * (MaxDivider + 1) + 16) + 2000;

	logic clock;
	logic reset;
	apbRequest request;
	apbResponse response;
	logic miso;
	spiPins pins;

	// divider the DUT should be shifting with
	logic [7:0] activeDivider;

	// card model state
	logic [7:0] cardShift;
	logic [7:0] cardResponse;
	int cardBits;
	logic [7:0] cardRx[$];
	logic [7:0] cardTx[$];

	// sclk timing monitor
	int sinceEdge;
	int risesInByte;
	logic lastSclk;

	sdSpiTop #(
		.ResetDivider(ResetDivider)
	) uut (
		.clock(clock),
		.reset(reset),
		.request(request),
		.response(response),
		.miso(miso),
		.pins(pins)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#50 clock = ~clock;
		end
	end

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// one APB access with setup and access phases, waiting on pready
	task automatic transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clock);
		request <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: write, pwdata: wdata};
		@(posedge clock);
		request.penable <= 1'b1;
		@(posedge clock);
		while (!response.pready)
		begin
			@(posedge clock);
		end
		rdata = response.prdata;
		checkValue("pslverr on completed access", 64'd0, 64'(response.pslverr));
		request <= '0;
	endtask

	task automatic writeRegister(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		transfer(1'b1, addr, wdata, unused);
	endtask

	task automatic readRegister(input logic [7:0] addr, output logic [31:0] rdata);
		transfer(1'b0, addr, 32'd0, rdata);
	endtask

	function automatic logic [31:0] controlWord(input logic [7:0] div, input logic csn,
		input logic startByte, input logic startBurst);
		logic [31:0] word;
		word = 32'd0;
		word[CtrlCsn] = csn;
		word[CtrlStartByte] = startByte;
		word[CtrlStartBurst] = startBurst;
		word[CtrlDividerLsb +: 8] = div;
		return word;
	endfunction

	// control write, then the csn pin must follow
	task automatic writeControl(input logic [7:0] div, input logic csn,
		input logic startByte, input logic startBurst);
		writeRegister(Control, controlWord(div, csn, startByte, startBurst));
		activeDivider = div;
		@(negedge clock);
		checkValue("csn pin after control write", 64'(csn), 64'(pins.csn));
	endtask

	// card puts out its first bit when selected
	always @(negedge pins.csn)
	begin
		cardBits = 0;
		cardResponse = 8'($urandom);
		miso <= cardResponse[7];
	end

	// card takes mosi on the rising edge
	always @(posedge pins.sclk)
	begin
		if (!pins.csn)
		begin
			cardShift = {cardShift[6:0], pins.mosi};
			cardBits = cardBits + 1;
			if (cardBits == 8)
			begin
				cardRx.push_back(cardShift);
				cardTx.push_back(cardResponse);
				cardBits = 0;
				cardResponse = 8'($urandom);
			end
		end
	end

	// next miso bit while sclk is low
	always @(negedge pins.sclk)
	begin
		if (!pins.csn)
		begin
			miso <= cardResponse[3'(7 - cardBits)];
		end
	end

	// every sclk half period inside a byte lasts divider + 1 clocks
	always @(posedge clock)
	begin
		if (reset)
		begin
			sinceEdge = 0;
			risesInByte = 0;
			lastSclk = 1'b0;
		end
		else
		begin
			sinceEdge = sinceEdge + 1;
			if (pins.sclk !== lastSclk)
			begin
				if (pins.sclk)
				begin
					// first rise of a byte follows the idle gap, not timed
					if ((risesInByte != 0) && (risesInByte != 8))
					begin
						checkValue("sclk low phase", 64'(activeDivider) + 64'd1, 64'(sinceEdge));
					end
					risesInByte = (risesInByte == 8) ? 1 : risesInByte + 1;
				end
				else
				begin
					checkValue("sclk high phase", 64'(activeDivider) + 64'd1, 64'(sinceEdge));
				end
				sinceEdge = 0;
				lastSclk = pins.sclk;
			end
		end
	end

	initial
	begin : watchdog
		repeat (TimeoutCycles) @(posedge clock);
		$display("timeout: run did not finish within %0d clock cycles", TimeoutCycles);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin : mainSequence
		logic [31:0] readData;
		logic [7:0] nextDivider;
		logic [7:0] newDivider;
		logic [7:0] dataByte;
		logic [63:0] sendWord;
		logic [63:0] expectedWord;
		void'($urandom(61856));
		request = '0;
		miso = 1'b1;
		reset = 1'b1;
		activeDivider = ResetDivider;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		// state straight after reset
		checkValue("csn pin after reset", 64'd1, 64'(pins.csn));
		checkValue("sclk pin after reset", 64'd0, 64'(pins.sclk));
		checkValue("mosi pin after reset", 64'd1, 64'(pins.mosi));
		readRegister(Control, readData);
		checkValue("reset csn bit", 64'd1, 64'(readData[CtrlCsn]));
		checkValue("reset busy bit", 64'd0, 64'(readData[CtrlStartByte]));
		checkValue("reset divider", 64'(ResetDivider), 64'(readData[CtrlDividerLsb +: 8]));

		for (int iter = 0; iter < Iterations; iter++)
		begin
			nextDivider = 8'($urandom_range(MaxDivider, 0));
			writeControl(nextDivider, 1'b0, 1'b0, 1'b0);

			// single byte exchange
			dataByte = 8'($urandom);
			writeRegister(Data, {24'd0, dataByte});
			cardRx.delete();
			cardTx.delete();
			writeControl(nextDivider, 1'b0, 1'b1, 1'b0);
			// waits on pready while the shifter runs
			readRegister(Data, readData);
			checkValue("single byte count at card", 64'd1, 64'(cardRx.size()));
			checkValue("single byte seen by card", 64'(dataByte), 64'(cardRx[0]));
			checkValue("single byte on Data", 64'(cardTx[0]), 64'(readData[7:0]));

			// eight byte burst
			sendWord = {32'($urandom), 32'($urandom)};
			writeRegister(SendLow, sendWord[31:0]);
			writeRegister(SendHigh, sendWord[63:32]);
			cardRx.delete();
			cardTx.delete();
			writeControl(nextDivider, 1'b0, 1'b0, 1'b1);
			// held off until the last byte is done, then deselects
			newDivider = 8'($urandom_range(MaxDivider, 0));
			writeControl(newDivider, 1'b1, 1'b0, 1'b0);
			checkValue("burst bytes before stalled write", 64'd8, 64'(cardRx.size()));
			readRegister(Control, readData);
			checkValue("stalled write csn bit", 64'd1, 64'(readData[CtrlCsn]));
			checkValue("busy after burst", 64'd0, 64'(readData[CtrlStartByte]));
			checkValue("stalled write divider", 64'(newDivider),
				64'(readData[CtrlDividerLsb +: 8]));

			// lowest byte goes first, first reply lands lowest
			for (int k = 0; k < 8; k++)
			begin
				checkValue("burst byte seen by card", 64'(sendWord[8 * k +: 8]), 64'(cardRx[k]));
				expectedWord[8 * k +: 8] = cardTx[k];
			end
			readRegister(ReceiveLow, readData);
			checkValue("burst ReceiveLow", 64'(expectedWord[31:0]), 64'(readData));
			readRegister(ReceiveHigh, readData);
			checkValue("burst ReceiveHigh", 64'(expectedWord[63:32]), 64'(readData));
		end

		repeat (4) @(posedge clock);
		if (uut.checks.failures != 0)
		begin
			$display("%0d assertion failures were reported", uut.checks.failures);
			$display("Something failed");
			$fatal(1, "assertion failures");
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
common/sdSpiPkg.sv
sdSpi/spiShiftEngine.sv
sdSpi/spiBurstQueue.sv
sdSpi/sdSpiRegisters.sv
logic/sdSpiTop.sv
dv/sdSpi_assertions.sv
dv/sdSpiTb.sv

// ==== Makefile ====
# Verilator build and run of the SD card SPI master testbench

VERILATOR ?= verilator
TOP ?= sdSpiTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_TEXT ?= Something failed
PASS_TEXT ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	elif grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED: run ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
